//--- spmv_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared definitions for the vertex SpMV compute unit
// Width types, vertex job, read command and result structs
// Controller state encoding
////////////////////////////////////////////////////////////////////////////

package spmv_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Width types
	////////////////////////////////////////////////////////////////////////////

	// Vertex number
	typedef logic [15:0] vertex_id_t;

	// Edge array index, also used directly as the read address
	typedef logic [23:0] edge_idx_t;

	// Out-degree of one vertex
	typedef logic [7:0] degree_t;

	// Fixed point edge data word
	typedef logic [31:0] edge_data_t;

	// Running totals
	typedef logic [31:0] edge_total_t;
	typedef logic [15:0] vertex_total_t;

	////////////////////////////////////////////////////////////////////////////
	// Structs
	////////////////////////////////////////////////////////////////////////////

	// One vertex job, 48 bits
	typedef struct packed {
		vertex_id_t vertex_id;
		edge_idx_t  edges_idx;
		degree_t    out_degree;
	} vertex_job_t;

	// Edge data read command, 40 bits
	typedef struct packed {
		edge_idx_t  address;
		vertex_id_t vertex_id;
	} read_cmd_t;

	// Per vertex result, 48 bits
	typedef struct packed {
		vertex_id_t vertex_id;
		edge_data_t sum;
	} vertex_result_t;

	// Vertex controller states
	typedef enum logic [2:0] {
		IDLE,
		LOAD,
		ISSUE,
		DRAIN,
		WRITE
	} ctrl_state_t;

endpackage

//--- sync_fifo.sv
////////////////////////////////////////////////////////////////////////////
// Synchronous FIFO on a register array
// Registered full, almost-full and empty flags, registered read port
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sync_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 16
) (
	input  logic             clock,
	input  logic             rstn,
	input  logic             push,
	input  logic [WIDTH-1:0] data_in,
	input  logic             pop,
	output logic [WIDTH-1:0] data_out,
	output logic             full,
	output logic             almost_full,
	output logic             empty
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic [CNT_W-1:0] count_next;
	logic             push_ok;
	logic             pop_ok;

	assign push_ok = push && !full;
	assign pop_ok  = pop && !empty;

	always_comb begin
		count_next = count;
		if (push_ok && !pop_ok) begin
			count_next = count + 1'b1;
		end else if (pop_ok && !push_ok) begin
			count_next = count - 1'b1;
		end
	end

	// Pointers, occupancy and flags; flags follow the next count so they
	// line up with the occupancy in every cycle
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr      <= '0;
			rd_ptr      <= '0;
			count       <= '0;
			empty       <= 1'b1;
			full        <= 1'b0;
			// Held high so nothing is offered before reset ends
			almost_full <= 1'b1;
		end else begin
			if (push_ok) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop_ok) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			count       <= count_next;
			empty       <= (count_next == '0);
			full        <= (count_next == CNT_W'(DEPTH));
			almost_full <= (count_next >= CNT_W'(DEPTH - 1));
		end
	end

	// Storage and read register; the popped entry shows on the next cycle
	always_ff @(posedge clock) begin
		if (push_ok) begin
			mem[wr_ptr] <= data_in;
		end
		if (pop_ok) begin
			data_out <= mem[rd_ptr];
		end
	end

endmodule

//--- vertex_control_fsm.sv
////////////////////////////////////////////////////////////////////////////
// Vertex controller
// Pops a job, issues one read per edge, waits for the data, writes result
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module vertex_control_fsm (
	input  logic                  clock,
	input  logic                  rstn,
	input  spmv_pkg::vertex_job_t head_job,
	input  logic                  buf_empty,
	input  logic                  cmd_almost_full,
	input  logic                  issue_done,
	input  logic                  return_done,
	output logic                  buf_pop,
	output logic                  clear_counts,
	output logic                  issue_edge,
	output logic                  write_result,
	output spmv_pkg::vertex_job_t job
);

	import spmv_pkg::*;

	ctrl_state_t state;
	ctrl_state_t state_next;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state <= IDLE;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			IDLE: begin
				if (!buf_empty) begin
					state_next = LOAD;
				end
			end
			LOAD: begin
				state_next = ISSUE;
			end
			// Degree zero is done on entry and falls through to DRAIN
			ISSUE: begin
				if (issue_done) begin
					state_next = DRAIN;
				end
			end
			// return_done already counts a strobe in this cycle
			DRAIN: begin
				if (return_done) begin
					state_next = WRITE;
				end
			end
			WRITE: begin
				state_next = IDLE;
			end
			default: begin
				state_next = IDLE;
			end
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Control strobes
	////////////////////////////////////////////////////////////////////////////

	assign buf_pop      = (state == IDLE) && !buf_empty;
	assign clear_counts = (state == LOAD);
	assign write_result = (state == WRITE);

	// One command per cycle, held off while the command buffer is nearly full
	assign issue_edge = (state == ISSUE) && !issue_done && !cmd_almost_full;

	// Popped job shows at the buffer output during LOAD
	always_ff @(posedge clock) begin
		if (state == LOAD) begin
			job <= head_job;
		end
	end

endmodule

//--- edge_counter.sv
////////////////////////////////////////////////////////////////////////////
// Issue and return counters for the vertex in progress
// Completion flags against the vertex out-degree
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module edge_counter (
	input  logic              clock,
	input  logic              rstn,
	input  logic              clear_counts,
	input  logic              issue_edge,
	input  logic              edge_data_valid,
	input  spmv_pkg::degree_t out_degree,
	output spmv_pkg::degree_t issue_index,
	output logic              issue_done,
	output logic              return_done
);

	import spmv_pkg::*;

	degree_t                   issue_count;
	degree_t                   return_count;
	logic [$bits(degree_t):0] returned_now;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			issue_count  <= '0;
			return_count <= '0;
		end else if (clear_counts) begin
			issue_count  <= '0;
			return_count <= '0;
		end else begin
			if (issue_edge) begin
				issue_count <= issue_count + 1'b1;
			end
			if (edge_data_valid) begin
				return_count <= return_count + 1'b1;
			end
		end
	end

	// Next command goes to edge number issue_count
	assign issue_index = issue_count;
	assign issue_done  = (issue_count == out_degree);

	// Includes a strobe arriving this cycle, so the last word ends the vertex
	// without waiting for the count register
	assign returned_now = {1'b0, return_count} +
		{{$bits(degree_t){1'b0}}, edge_data_valid};
	assign return_done  = (returned_now == {1'b0, out_degree});

endmodule

//--- read_command_port.sv
////////////////////////////////////////////////////////////////////////////
// Edge read command port
// Address formation, command buffer, bus request and command output
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module read_command_port #(
	parameter int CMD_BUF_DEPTH = 16
) (
	input  logic                  clock,
	input  logic                  rstn,
	input  logic                  issue_edge,
	input  spmv_pkg::vertex_job_t job,
	input  spmv_pkg::degree_t     issue_index,
	input  logic                  read_command_bus_grant,
	output logic                  read_command_bus_request,
	output spmv_pkg::read_cmd_t   read_command_out,
	output logic                  read_command_valid,
	output logic                  cmd_almost_full
);

	import spmv_pkg::*;

	read_cmd_t new_cmd;
	logic      cmd_pop;
	logic      cmd_empty;

	// Edge i of the vertex sits at edges_idx + i
	assign new_cmd.address   = job.edges_idx + edge_idx_t'(issue_index);
	assign new_cmd.vertex_id = job.vertex_id;

	////////////////////////////////////////////////////////////////////////////
	// Command buffer
	////////////////////////////////////////////////////////////////////////////

	sync_fifo #(
		.WIDTH($bits(read_cmd_t)),
		.DEPTH(CMD_BUF_DEPTH    )
	) cmd_buffer (
		.clock      (clock           ),
		.rstn       (rstn            ),
		.push       (issue_edge      ),
		.data_in    (new_cmd         ),
		.pop        (cmd_pop         ),
		.data_out   (read_command_out),
		.full       (                ),
		.almost_full(cmd_almost_full ),
		.empty      (cmd_empty       )
	);

	////////////////////////////////////////////////////////////////////////////
	// Bus request and grant
	////////////////////////////////////////////////////////////////////////////

	assign read_command_bus_request = !cmd_empty;

	// A grant with nothing requested is dropped
	assign cmd_pop = read_command_bus_grant && read_command_bus_request;

	// Popped command leaves the buffer read register one cycle after the grant
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			read_command_valid <= 1'b0;
		end else begin
			read_command_valid <= cmd_pop;
		end
	end

endmodule

//--- sum_accumulator.sv
////////////////////////////////////////////////////////////////////////////
// Fixed point sum of returned edge data
// Result pulse per vertex, running vertex and edge totals
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sum_accumulator (
	input  logic                     clock,
	input  logic                     rstn,
	input  logic                     clear_counts,
	input  logic                     edge_data_valid,
	input  logic                     write_result,
	input  spmv_pkg::edge_data_t     edge_data_in,
	input  spmv_pkg::vertex_id_t     vertex_id,
	output spmv_pkg::vertex_result_t vertex_result_out,
	output logic                     vertex_result_valid,
	output spmv_pkg::vertex_total_t  vertex_num_counter,
	output spmv_pkg::edge_total_t    edge_num_counter
);

	import spmv_pkg::*;

	edge_data_t sum;

	////////////////////////////////////////////////////////////////////////////
	// Running sum and result payload
	////////////////////////////////////////////////////////////////////////////

	// Wraps modulo 2^32
	always_ff @(posedge clock) begin
		if (clear_counts || write_result) begin
			sum <= '0;
		end else if (edge_data_valid) begin
			sum <= sum + edge_data_in;
		end
		if (write_result) begin
			vertex_result_out.vertex_id <= vertex_id;
			vertex_result_out.sum       <= sum;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Result strobe and totals
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_result_valid <= 1'b0;
			vertex_num_counter  <= '0;
			edge_num_counter    <= '0;
		end else begin
			vertex_result_valid <= write_result;
			if (write_result) begin
				vertex_num_counter <= vertex_num_counter + 1'b1;
			end
			// Every returned word counts, whatever vertex it belongs to
			if (edge_data_valid) begin
				edge_num_counter <= edge_num_counter + 1'b1;
			end
		end
	end

endmodule

//--- cu_vertex_spmv.sv
////////////////////////////////////////////////////////////////////////////
// Vertex SpMV compute unit, top level
// Vertex job buffer, controller, edge counters, read port, accumulator
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module cu_vertex_spmv #(
	parameter int VERTEX_BUF_DEPTH = 32,
	parameter int CMD_BUF_DEPTH    = 16
) (
	input  logic                     clock,
	input  logic                     rstn,
	input  spmv_pkg::vertex_job_t    vertex_job,
	input  logic                     vertex_job_valid,
	output logic                     vertex_job_request,
	input  logic                     read_command_bus_grant,
	output logic                     read_command_bus_request,
	output spmv_pkg::read_cmd_t      read_command_out,
	output logic                     read_command_valid,
	input  spmv_pkg::edge_data_t     edge_data_in,
	input  logic                     edge_data_valid,
	output spmv_pkg::vertex_result_t vertex_result_out,
	output logic                     vertex_result_valid,
	output spmv_pkg::vertex_total_t  vertex_num_counter,
	output spmv_pkg::edge_total_t    edge_num_counter
);

	import spmv_pkg::*;

	vertex_job_t head_job;
	vertex_job_t job;
	degree_t     issue_index;
	logic        vbuf_almost_full;
	logic        vbuf_empty;
	logic        buf_pop;
	logic        clear_counts;
	logic        issue_edge;
	logic        write_result;
	logic        issue_done;
	logic        return_done;
	logic        cmd_almost_full;

	// Room for one more job after the request drops
	assign vertex_job_request = !vbuf_almost_full;

	sync_fifo #(
		.WIDTH($bits(vertex_job_t)),
		.DEPTH(VERTEX_BUF_DEPTH   )
	) vertex_buffer (
		.clock(clock), .rstn(rstn),
		.push(vertex_job_valid), .data_in(vertex_job),
		.pop(buf_pop), .data_out(head_job),
		.full(), .almost_full(vbuf_almost_full), .empty(vbuf_empty)
	);

	vertex_control_fsm u_control (
		.clock(clock), .rstn(rstn),
		.head_job(head_job), .buf_empty(vbuf_empty),
		.cmd_almost_full(cmd_almost_full),
		.issue_done(issue_done), .return_done(return_done),
		.buf_pop(buf_pop), .clear_counts(clear_counts),
		.issue_edge(issue_edge), .write_result(write_result),
		.job(job)
	);

	edge_counter u_counter (
		.clock(clock), .rstn(rstn),
		.clear_counts(clear_counts), .issue_edge(issue_edge),
		.edge_data_valid(edge_data_valid), .out_degree(job.out_degree),
		.issue_index(issue_index),
		.issue_done(issue_done), .return_done(return_done)
	);

	read_command_port #(
		.CMD_BUF_DEPTH(CMD_BUF_DEPTH)
	) u_read_port (
		.clock(clock), .rstn(rstn),
		.issue_edge(issue_edge), .job(job), .issue_index(issue_index),
		.read_command_bus_grant(read_command_bus_grant),
		.read_command_bus_request(read_command_bus_request),
		.read_command_out(read_command_out),
		.read_command_valid(read_command_valid),
		.cmd_almost_full(cmd_almost_full)
	);

	sum_accumulator u_accum (
		.clock(clock), .rstn(rstn),
		.clear_counts(clear_counts), .edge_data_valid(edge_data_valid),
		.write_result(write_result), .edge_data_in(edge_data_in),
		.vertex_id(job.vertex_id),
		.vertex_result_out(vertex_result_out),
		.vertex_result_valid(vertex_result_valid),
		.vertex_num_counter(vertex_num_counter),
		.edge_num_counter(edge_num_counter)
	);

endmodule

//--- tb_cu_vertex_spmv.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the vertex SpMV compute unit
// Random jobs, grant driver, edge memory responder, reference model
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_cu_vertex_spmv;

	import spmv_pkg::*;

	localparam int JOB_WAIT_LIMIT = 2000;
	localparam int STALL_LIMIT    = 600;
	localparam int DRAIN_LIMIT    = 40000;

	logic           clock;
	logic           rstn;
	vertex_job_t    vertex_job;
	logic           vertex_job_valid;
	logic           vertex_job_request;
	logic           read_command_bus_grant;
	logic           read_command_bus_request;
	read_cmd_t      read_command_out;
	logic           read_command_valid;
	edge_data_t     edge_data_in;
	logic           edge_data_valid;
	vertex_result_t vertex_result_out;
	logic           vertex_result_valid;
	vertex_total_t  vertex_num_counter;
	edge_total_t    edge_num_counter;

	int             check_errors = 0;
	int             other_errors = 0;
	int             jobs_sent = 0;
	logic           hold_grants = 1'b0;
	logic           job_allowed;
	logic           grant_pending;
	vertex_total_t  exp_vertices = '0;
	edge_total_t    exp_edges = '0;

	// Edge memory, filled lazily with random words
	edge_data_t     mem [edge_idx_t];
	read_cmd_t      exp_cmds [$];
	vertex_result_t exp_results [$];
	// Addresses of commands seen on the bus, waiting for their data
	edge_idx_t      pending [$];

	cu_vertex_spmv #(
		.VERTEX_BUF_DEPTH(32),
		.CMD_BUF_DEPTH   (16)
	) UUT (
		.clock                   (clock                   ),
		.rstn                    (rstn                    ),
		.vertex_job              (vertex_job              ),
		.vertex_job_valid        (vertex_job_valid        ),
		.vertex_job_request      (vertex_job_request      ),
		.read_command_bus_grant  (read_command_bus_grant  ),
		.read_command_bus_request(read_command_bus_request),
		.read_command_out        (read_command_out        ),
		.read_command_valid      (read_command_valid      ),
		.edge_data_in            (edge_data_in            ),
		.edge_data_valid         (edge_data_valid         ),
		.vertex_result_out       (vertex_result_out       ),
		.vertex_result_valid     (vertex_result_valid     ),
		.vertex_num_counter      (vertex_num_counter      ),
		.edge_num_counter        (edge_num_counter        )
	);

	initial begin
		clock = 1'b0;
		forever begin
			#2 clock = ~clock;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic check_result(input string name, input vertex_result_t exp,
			input vertex_result_t act);
		if (act !== exp) begin
			check_errors++;
			$display("CHECK FAILED %s: expected id %h sum %h, actual id %h sum %h",
				name, exp.vertex_id, exp.sum, act.vertex_id, act.sum);
		end
	endtask

	task automatic check_command(input string name, input read_cmd_t exp,
			input read_cmd_t act);
		if (act !== exp) begin
			check_errors++;
			$display("CHECK FAILED %s: expected addr %h id %h, actual addr %h id %h",
				name, exp.address, exp.vertex_id, act.address, act.vertex_id);
		end
	endtask

	task automatic check_total_vertices(input string name, input vertex_total_t exp,
			input vertex_total_t act);
		if (act !== exp) begin
			check_errors++;
			$display("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act);
		end
	endtask

	task automatic check_total_edges(input string name, input edge_total_t exp,
			input edge_total_t act);
		if (act !== exp) begin
			check_errors++;
			$display("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act);
		end
	endtask

	task automatic check_level(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			check_errors++;
			$display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	task automatic report_failure(input string msg);
		other_errors++;
		$display("ERROR: %s", msg);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Job driver and reference model
	////////////////////////////////////////////////////////////////////////////

	// Every sixteenth job has no edges
	function automatic degree_t pick_degree();
		if (jobs_sent % 16 == 0) begin
			return '0;
		end
		return degree_t'($urandom_range(0, 12));
	endfunction

	// Drives one job strobe and records its commands and result
	task automatic drive_job(input degree_t degree);
		vertex_job_t    j;
		vertex_result_t res;
		read_cmd_t      cmd;
		edge_idx_t      a;
		edge_data_t     sum;
		int             i;
		j.vertex_id  = vertex_id_t'($urandom);
		// Some ranges sit at the top of the address space and wrap
		if ($urandom_range(0, 7) == 0) begin
			j.edges_idx = edge_idx_t'(32'h00FF_FFF8 + $urandom_range(0, 7));
		end else begin
			j.edges_idx = edge_idx_t'($urandom_range(0, 4095));
		end
		j.out_degree = degree;
		sum = '0;
		for (i = 0; i < int'(degree); i++) begin
			a = j.edges_idx + edge_idx_t'(i);
			if (!mem.exists(a)) begin
				mem[a] = $urandom;
			end
			sum = sum + mem[a];
			cmd.address   = a;
			cmd.vertex_id = j.vertex_id;
			exp_cmds.push_back(cmd);
		end
		res.vertex_id = j.vertex_id;
		res.sum       = sum;
		exp_results.push_back(res);
		exp_vertices = exp_vertices + 1'b1;
		exp_edges    = exp_edges + edge_total_t'(degree);
		jobs_sent++;
		vertex_job       = j;
		vertex_job_valid = 1'b1;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clock);
			#1;
			vertex_job_valid = 1'b0;
		end
	endtask

	// Waits for permission from the previous cycle, then strobes a job
	task automatic send_job();
		int t;
		for (t = 0; t <= JOB_WAIT_LIMIT; t++) begin
			@(posedge clock);
			#1;
			vertex_job_valid = 1'b0;
			if (job_allowed) begin
				break;
			end
		end
		if (t > JOB_WAIT_LIMIT) begin
			report_failure("timed out waiting for vertex_job_request");
		end else begin
			drive_job(pick_degree());
		end
	endtask

	task automatic send_batch(input int count);
		int n;
		for (n = 0; n < count; n++) begin
			send_job();
			if ($urandom_range(0, 3) == 0) begin
				idle_cycles(int'($urandom_range(1, 8)));
			end
		end
		idle_cycles(1);
	endtask

	task automatic end_run();
		$display("Summary: %0d jobs, %0d value mismatches, %0d other failures",
			jobs_sent, check_errors, other_errors);
		if (check_errors == 0 && other_errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Grant driver and memory responder
	////////////////////////////////////////////////////////////////////////////

	initial begin
		int gap;
		read_command_bus_grant = 1'b0;
		gap = 0;
		forever begin
			@(posedge clock);
			#1;
			// Grants also land while nothing is requested
			if (rstn && !hold_grants && gap == 0) begin
				read_command_bus_grant = 1'b1;
				gap = $urandom_range(0, 3);
			end else begin
				read_command_bus_grant = 1'b0;
				if (gap > 0) begin
					gap--;
				end
			end
		end
	end

	initial begin
		edge_idx_t a;
		int        delay;
		edge_data_valid = 1'b0;
		edge_data_in    = '0;
		delay = 0;
		forever begin
			@(posedge clock);
			#1;
			edge_data_valid = 1'b0;
			if (pending.size() > 0) begin
				if (delay == 0) begin
					a = pending.pop_front();
					edge_data_in    = mem.exists(a) ? mem[a] : '0;
					edge_data_valid = 1'b1;
					delay = $urandom_range(0, 4);
				end else begin
					delay--;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Output monitor, sampled mid-cycle
	////////////////////////////////////////////////////////////////////////////

	initial begin
		grant_pending = 1'b0;
		job_allowed   = 1'b0;
		forever begin
			@(negedge clock);
			if (!rstn) begin
				grant_pending = 1'b0;
				job_allowed   = 1'b0;
			end else begin
				// Command is due exactly one cycle after an accepted grant
				if (read_command_valid) begin
					if (!grant_pending) begin
						report_failure("read command appeared without a grant before it");
					end
					if (exp_cmds.size() == 0) begin
						report_failure("read command appeared with none outstanding");
					end else begin
						check_command("read command", exp_cmds.pop_front(), read_command_out);
					end
					pending.push_back(read_command_out.address);
				end else if (grant_pending) begin
					report_failure("granted read command did not appear one cycle later");
				end
				grant_pending = read_command_bus_grant && read_command_bus_request;
				job_allowed   = vertex_job_request;
				if (vertex_result_valid) begin
					if (exp_results.size() == 0) begin
						report_failure("vertex result appeared with no job outstanding");
					end else begin
						check_result("vertex result", exp_results.pop_front(), vertex_result_out);
					end
				end
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		int   t;
		logic fell;
		rstn             = 1'b0;
		vertex_job       = '0;
		vertex_job_valid = 1'b0;
		void'($urandom(32'h86f9_c8ba));
		repeat (4) @(posedge clock);
		#1;
		rstn = 1'b1;
		@(negedge clock);
		check_level("job request after reset", 1'b0, vertex_job_request);
		check_level("command request after reset", 1'b0, read_command_bus_request);
		check_level("command valid after reset", 1'b0, read_command_valid);
		check_level("result valid after reset", 1'b0, vertex_result_valid);
		check_total_vertices("vertex total after reset", '0, vertex_num_counter);
		check_total_edges("edge total after reset", '0, edge_num_counter);

		send_batch(40);

		// Let the backlog shrink so the stall starts from a nearly empty buffer
		for (t = 0; t <= DRAIN_LIMIT && exp_results.size() > 2; t++) begin
			idle_cycles(1);
		end
		if (exp_results.size() > 2) begin
			report_failure("timed out waiting for the job backlog to shrink");
		end

		// Back-pressure with grants withheld
		hold_grants = 1'b1;
		fell = 1'b0;
		for (t = 0; t < STALL_LIMIT && !fell; t++) begin
			@(posedge clock);
			#1;
			vertex_job_valid = 1'b0;
			if (!job_allowed) begin
				fell = 1'b1;
			end else begin
				drive_job(pick_degree());
			end
		end
		if (!fell) begin
			report_failure("vertex_job_request never fell while grants were withheld");
		end
		idle_cycles(40);
		check_level("job request while grants held", 1'b0, vertex_job_request);
		hold_grants = 1'b0;

		send_batch(40);

		for (t = 0; t <= DRAIN_LIMIT && (exp_results.size() > 0 || pending.size() > 0); t++) begin
			idle_cycles(1);
		end
		if (exp_results.size() > 0 || pending.size() > 0) begin
			report_failure("timed out waiting for outstanding vertex results");
		end
		idle_cycles(4);
		check_total_vertices("vertex total", exp_vertices, vertex_num_counter);
		check_total_edges("edge total", exp_edges, edge_num_counter);
		check_level("command request when idle", 1'b0, read_command_bus_request);
		if (exp_cmds.size() != 0) begin
			report_failure("expected read commands never appeared");
		end
		end_run();
	end

endmodule

//--- build.f
spmv_pkg.sv
sync_fifo.sv
vertex_control_fsm.sv
edge_counter.sv
read_command_port.sv
sum_accumulator.sv
cu_vertex_spmv.sv
tb_cu_vertex_spmv.sv

//--- Makefile
# Verilator simulation of the vertex SpMV compute unit

TOOL      = verilator
FLAGS     = --binary --timing -j 0
TOP       = tb_cu_vertex_spmv
FILELIST  = build.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = Finished with no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "TEST PASSED"; \
	else \
		echo "TEST FAILED"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
